//--- hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int data_w     = 16; // machine word and pc width
	localparam int reg_count  = 16; // r0 reads zero
	localparam int reg_addr_w = 4;

	// lsb of each instruction field
	localparam int op_lsb  = 12;
	localparam int op_w    = 4;
	localparam int rd_lsb  = 8;
	localparam int rs1_lsb = 4;
	localparam int rs2_lsb = 0;  // shared with imm4
	localparam int imm4_w  = 4;  // signed
	localparam int imm8_w  = 8;  // LDI and BZ only

	// flag bits as {n, v, z}
	localparam int flag_w = 3;
	localparam int flag_n = 2;
	localparam int flag_v = 1;
	localparam int flag_z = 0;

	typedef enum logic [op_w-1:0] {
		op_nop   = 4'h0,
		op_add   = 4'h1,
		op_sub   = 4'h2,
		op_and   = 4'h3,
		op_or    = 4'h4,
		op_xor   = 4'h5,
		op_addi  = 4'h6, // rs1 + sext imm4
		op_ldi   = 4'h7, // zext imm8
		op_ld    = 4'h8,
		op_st    = 4'h9,
		op_bz    = 4'ha, // pc += sext imm8 + 1
		op_accw  = 4'hb,
		op_accr  = 4'hc,
		op_accgo = 4'hd,
		op_halt  = 4'hf  // 4'he reserved and runs as nop
	} opcode_e;

endpackage

`default_nettype wire

//--- hw/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

	localparam int acc_addr_w = 3; // 8 accelerator registers

	// where the write-back value comes from
	typedef enum logic [1:0] {
		wb_none = 2'd0,
		wb_alu  = 2'd1,
		wb_mem  = 2'd2,
		wb_bus  = 2'd3
	} wb_src_e;

	// direction code on bus_rdwr
	typedef enum logic [1:0] {
		bus_idle  = 2'b00,
		bus_write = 2'b01,
		bus_read  = 2'b10
	} bus_dir_e;

endpackage

`default_nettype wire

//--- hw/stage_if.sv
`timescale 1ns/1ns
`default_nettype none

// decode to execute
interface ex_ctrl_if import cpu_isa_pkg::*, cpu_bus_pkg::*; ();
	logic                  valid;
	opcode_e               op;
	logic [reg_addr_w-1:0] dest;
	logic [reg_addr_w-1:0] src1;
	logic [reg_addr_w-1:0] src2;   // rd for ST and ACCW
	logic [data_w-1:0]     data1;
	logic [data_w-1:0]     data2;
	logic [data_w-1:0]     imm;    // already extended
	logic                  use_imm;
	wb_src_e               wb_src;
	logic                  mem_rd;
	logic                  mem_wr;
	logic                  bus_wr;
	logic                  store_data_sel;

	modport driver (output valid, op, dest, src1, src2, data1, data2, imm, use_imm,
		wb_src, mem_rd, mem_wr, bus_wr, store_data_sel);
	modport receiver (input valid, op, dest, src1, src2, data1, data2, imm, use_imm,
		wb_src, mem_rd, mem_wr, bus_wr, store_data_sel);
endinterface

// execute to write-back
interface wb_if import cpu_isa_pkg::*, cpu_bus_pkg::*; ();
	logic                  valid;
	logic [data_w-1:0]     alu_out;    // also the dmem address
	logic [data_w-1:0]     store_data;
	logic [reg_addr_w-1:0] dest;
	wb_src_e               wb_src;
	logic                  mem_rd;
	logic                  mem_wr;
	logic                  bus_wr;
	logic                  bus_rd;
	logic [acc_addr_w-1:0] acc_addr;

	modport driver (output valid, alu_out, store_data, dest, wb_src, mem_rd, mem_wr,
		bus_wr, bus_rd, acc_addr);
	modport receiver (input valid, alu_out, store_data, dest, wb_src, mem_rd, mem_wr,
		bus_wr, bus_rd, acc_addr);
endinterface

`default_nettype wire

//--- hw/cpu_control.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_control
	import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [data_w-1:0]     instr,
	input  logic [data_w-1:0]     rd1_data,
	input  logic [data_w-1:0]     rd2_data,
	input  logic [flag_w-1:0]     flags,
	input  logic                  flags_pending,
	input  logic                  load_wait,
	input  logic                  accel_done,
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	output logic                  pc_hold,
	output logic                  branch_taken,
	output logic [data_w-1:0]     branch_offset,
	output logic                  halted,
	output logic                  accel_start,
	output logic                  accel_en,
	ex_ctrl_if.driver             ex
);

	typedef enum logic [1:0] {acc_idle, acc_busy, acc_halted} acc_state_e;

	acc_state_e            state;
	acc_state_e            state_nxt;
	opcode_e               op;
	logic [reg_addr_w-1:0] f_rd;
	logic [imm4_w-1:0]     imm4;
	logic [imm8_w-1:0]     imm8;
	logic [data_w-1:0]     d_imm;
	logic                  d_valid;
	logic                  d_use_imm;
	logic                  d_mem_rd;
	logic                  d_mem_wr;
	logic                  d_bus_wr;
	logic                  d_sel;
	wb_src_e               d_wb_src;
	logic                  issue;   // instr goes down the pipe this cycle
	logic                  bz_wait;
	logic                  go_wait;

	assign op   = opcode_e'(instr[op_lsb +: op_w]);
	assign f_rd = instr[rd_lsb +: reg_addr_w];
	assign imm4 = instr[rs2_lsb +: imm4_w];
	assign imm8 = instr[0 +: imm8_w];

	assign rs1_addr = instr[rs1_lsb +: reg_addr_w];
	// ST and ACCW read rd on port 2 as store data
	assign rs2_addr = (op == op_st || op == op_accw) ? f_rd : instr[rs2_lsb +: reg_addr_w];

	assign branch_offset = {{(data_w-imm8_w){imm8[imm8_w-1]}}, imm8} + 1'b1;

	always_comb begin
		d_valid   = 1'b1;
		d_imm     = {{(data_w-imm4_w){imm4[imm4_w-1]}}, imm4}; // sext imm4
		d_use_imm = 1'b0;
		d_wb_src  = wb_none;
		d_mem_rd  = 1'b0;
		d_mem_wr  = 1'b0;
		d_bus_wr  = 1'b0;
		d_sel     = 1'b0;
		case (op)
			op_add, op_sub, op_and, op_or, op_xor: d_wb_src = wb_alu;
			op_addi: begin
				d_use_imm = 1'b1;
				d_wb_src  = wb_alu;
			end
			op_ldi: begin
				d_imm     = {{(data_w-imm8_w){1'b0}}, imm8};
				d_use_imm = 1'b1;
				d_wb_src  = wb_alu;
			end
			op_ld: begin
				d_use_imm = 1'b1; // address rs1 + imm4
				d_wb_src  = wb_mem;
				d_mem_rd  = 1'b1;
			end
			op_st: begin
				d_use_imm = 1'b1;
				d_mem_wr  = 1'b1;
				d_sel     = 1'b1;
			end
			op_accw: begin
				d_bus_wr = 1'b1; // reg addr from imm[2:0]
				d_sel    = 1'b1;
			end
			op_accr: d_wb_src = wb_bus;
			default: d_valid = 1'b0; // nop, bz, accgo, halt stay in decode
		endcase
	end

	assign bz_wait = op == op_bz && flags_pending;           // flags not final yet
	assign go_wait = op == op_accgo && ex.valid && ex.bus_wr; // let ACCW reach the bus

	// stall, branch and accelerator sequencing
	always_comb begin
		state_nxt    = state;
		pc_hold      = 1'b1;
		branch_taken = 1'b0;
		accel_start  = 1'b0;
		issue        = 1'b0;
		case (state)
			acc_idle: begin
				if (load_wait) begin
					pc_hold = 1'b1; // whole pipe frozen
				end else if (op == op_halt) begin
					state_nxt = acc_halted;
				end else if (op == op_accgo) begin
					if (!go_wait) begin
						accel_start = 1'b1;
						pc_hold     = 1'b0; // step past ACCGO and wait in busy
						state_nxt   = acc_busy;
					end
				end else if (!bz_wait) begin
					issue        = 1'b1;
					branch_taken = op == op_bz && flags[flag_z];
					pc_hold      = 1'b0;
				end
			end
			acc_busy: begin
				if (accel_done)
					state_nxt = acc_idle;
			end
			acc_halted: state_nxt = acc_halted; // only reset leaves
			default: state_nxt = acc_idle;
		endcase
	end

	assign accel_en = accel_start || state == acc_busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= acc_idle;
			halted <= 1'b0;
		end else begin
			state  <= state_nxt;
			halted <= state == acc_halted && !load_wait; // last load done too
		end
	end

	// stage-1 register control part
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex.valid  <= 1'b0;
			ex.op     <= op_nop;
			ex.wb_src <= wb_none;
			ex.mem_rd <= 1'b0;
			ex.mem_wr <= 1'b0;
			ex.bus_wr <= 1'b0;
		end else if (!load_wait) begin
			ex.valid  <= issue && d_valid; // bubble on stall
			ex.op     <= op;
			ex.wb_src <= d_wb_src;
			ex.mem_rd <= d_mem_rd;
			ex.mem_wr <= d_mem_wr;
			ex.bus_wr <= d_bus_wr;
		end
	end

	// operands and fields
	always_ff @(posedge clk) begin
		if (!load_wait) begin
			ex.dest           <= f_rd;
			ex.src1           <= rs1_addr;
			ex.src2           <= rs2_addr;
			ex.data1          <= rd1_data;
			ex.data2          <= rd2_data;
			ex.imm            <= d_imm;
			ex.use_imm        <= d_use_imm;
			ex.store_data_sel <= d_sel;
		end
	end

	a_en_until_done: assert property (@(posedge clk) disable iff (!rst_n)
		accel_en && !accel_done |=> accel_en);

	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted);

endmodule

`default_nettype wire

//--- hw/fetch_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_regfile
	import cpu_isa_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pc_hold,
	input  logic                  branch_taken,
	input  logic [data_w-1:0]     branch_offset,
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	input  logic                  rf_wen,
	input  logic [reg_addr_w-1:0] rf_waddr,
	input  logic [data_w-1:0]     rf_wdata,
	output logic [data_w-1:0]     imem_addr,
	output logic [data_w-1:0]     rd1_data,
	output logic [data_w-1:0]     rd2_data
);

	logic [data_w-1:0] pc;
	logic [data_w-1:0] regs [reg_count];

	// read port with r0 at zero and the value being written showing through
	function automatic logic [data_w-1:0] rd_port(input logic [reg_addr_w-1:0] a);
		if (a == '0)
			return '0;
		if (rf_wen && rf_waddr == a)
			return rf_wdata;
		return regs[a];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (branch_taken)
			pc <= pc + branch_offset; // relative to the BZ itself
		else if (!pc_hold)
			pc <= pc + 1'b1;
	end

	assign imem_addr = pc; // imem answers in the same cycle

	always_ff @(posedge clk) begin
		if (rf_wen && rf_waddr != '0)
			regs[rf_waddr] <= rf_wdata;
	end

	always_comb begin
		rd1_data = rd_port(rs1_addr);
		rd2_data = rd_port(rs2_addr);
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(rf_wen && rf_waddr == '0));

endmodule

`default_nettype wire

//--- hw/execute_alu.sv
`timescale 1ns/1ns
`default_nettype none

module execute_alu
	import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,   // load freeze
	input  logic                  rf_wen,
	input  logic [reg_addr_w-1:0] rf_waddr,
	input  logic [data_w-1:0]     rf_wdata,
	output logic [flag_w-1:0]     flags,
	output logic                  flags_pending,
	ex_ctrl_if.receiver           ex,
	wb_if.driver                  wb
);

	logic              fwd_a_sel;
	logic              fwd_b_sel;
	logic [data_w-1:0] op_a;
	logic [data_w-1:0] reg_b;   // forwarded rs2 or rd
	logic [data_w-1:0] op_b;
	logic [data_w-1:0] result;
	logic              ovf;
	logic              sets_flags;

	// forward from the write-back stage
	assign fwd_a_sel = rf_wen && rf_waddr == ex.src1;
	assign fwd_b_sel = rf_wen && rf_waddr == ex.src2;
	assign op_a  = fwd_a_sel ? rf_wdata : ex.data1;
	assign reg_b = fwd_b_sel ? rf_wdata : ex.data2;
	assign op_b  = ex.use_imm ? ex.imm : reg_b;

	always_comb begin
		result = op_b; // LDI and bus ops pass b
		ovf    = 1'b0;
		case (ex.op)
			op_add, op_addi, op_ld, op_st: begin
				result = op_a + op_b;
				ovf    = op_a[data_w-1] == op_b[data_w-1] && result[data_w-1] != op_a[data_w-1];
			end
			op_sub: begin
				result = op_a - op_b;
				ovf    = op_a[data_w-1] != op_b[data_w-1] && result[data_w-1] != op_a[data_w-1];
			end
			op_and:  result = op_a & op_b;
			op_or:   result = op_a | op_b;
			op_xor:  result = op_a ^ op_b;
			default: result = op_b;
		endcase
	end

	assign sets_flags    = ex.op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi};
	assign flags_pending = ex.valid && sets_flags; // BZ in decode must wait

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (flags_pending && !stall) begin
			flags[flag_n] <= result[data_w-1];
			flags[flag_v] <= ovf;
			flags[flag_z] <= result == '0;
		end
	end

	// stage-2 register held during the load freeze
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb.valid  <= 1'b0;
			wb.wb_src <= wb_none;
			wb.mem_rd <= 1'b0;
			wb.mem_wr <= 1'b0;
			wb.bus_wr <= 1'b0;
			wb.bus_rd <= 1'b0;
		end else if (!stall) begin
			wb.valid  <= ex.valid;
			wb.wb_src <= ex.wb_src;
			wb.mem_rd <= ex.mem_rd;
			wb.mem_wr <= ex.mem_wr;
			wb.bus_wr <= ex.bus_wr;
			wb.bus_rd <= ex.wb_src == wb_bus; // ACCR
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wb.alu_out    <= result;
			wb.store_data <= ex.store_data_sel ? reg_b : result;
			wb.dest       <= ex.dest;
			wb.acc_addr   <= ex.imm[acc_addr_w-1:0];
		end
	end

	// r0 as a source must still be zero after forwarding
	a_no_fwd_r0: assert property (@(posedge clk) disable iff (!rst_n)
		ex.valid && ex.src1 == '0 |-> op_a == '0);

endmodule

`default_nettype wire

//--- hw/writeback_mux.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_mux
	import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [data_w-1:0]     dmem_rdata,
	input  logic [data_w-1:0]     bus_rdata,
	output logic                  dmem_ren,
	output logic                  dmem_wren,
	output logic [data_w-1:0]     dmem_addr,
	output logic [data_w-1:0]     dmem_wdata,
	output bus_dir_e              bus_rdwr,
	output logic [acc_addr_w-1:0] bus_addr,
	output logic [data_w-1:0]     bus_wdata,
	output logic                  rf_wen,
	output logic [reg_addr_w-1:0] rf_waddr,
	output logic [data_w-1:0]     rf_wdata,
	output logic                  load_wait,
	wb_if.receiver                wb
);

	logic                  load_pend; // read data arrives this cycle
	logic [reg_addr_w-1:0] load_dest;

	assign load_wait = wb.valid && wb.mem_rd && !load_pend;

	// LD stays in this stage for the freeze so dmem is read only once
	assign dmem_ren   = load_wait;
	assign dmem_wren  = wb.valid && wb.mem_wr;
	assign dmem_addr  = wb.alu_out;
	assign dmem_wdata = wb.store_data;

	// accelerator register bus
	assign bus_rdwr  = !wb.valid ? bus_idle :
	                   wb.bus_wr ? bus_write :
	                   wb.bus_rd ? bus_read : bus_idle;
	assign bus_addr  = wb.acc_addr;
	assign bus_wdata = wb.store_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			load_pend <= 1'b0;
		else
			load_pend <= load_wait;
	end

	always_ff @(posedge clk) begin
		if (load_wait)
			load_dest <= wb.dest;
	end

	always_comb begin
		rf_waddr = load_pend ? load_dest : wb.dest;
		if (load_pend)
			rf_wdata = dmem_rdata;
		else if (wb.wb_src == wb_bus)
			rf_wdata = bus_rdata; // combinational from bus_addr
		else
			rf_wdata = wb.alu_out;
		rf_wen = (load_pend || (wb.valid && (wb.wb_src == wb_alu || wb.wb_src == wb_bus)))
			&& rf_waddr != '0;
	end

	a_dmem_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_ren && dmem_wren));

endmodule

`default_nettype wire

//--- hw/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu
	import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [data_w-1:0]     imem_data,
	input  logic [data_w-1:0]     dmem_rdata,
	input  logic [data_w-1:0]     bus_rdata,
	input  logic                  accel_done,
	output logic [data_w-1:0]     imem_addr,
	output logic                  dmem_ren,
	output logic                  dmem_wren,
	output logic [data_w-1:0]     dmem_addr,
	output logic [data_w-1:0]     dmem_wdata,
	output bus_dir_e              bus_rdwr,
	output logic [acc_addr_w-1:0] bus_addr,
	output logic [data_w-1:0]     bus_wdata,
	output logic                  accel_start,
	output logic                  accel_en,
	output logic                  halted
);

	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [data_w-1:0]     rd1_data;
	logic [data_w-1:0]     rd2_data;
	logic                  pc_hold;
	logic                  branch_taken;
	logic [data_w-1:0]     branch_offset;
	logic [flag_w-1:0]     flags;
	logic                  flags_pending;
	logic                  load_wait;     // also freezes execute
	logic                  rf_wen;
	logic [reg_addr_w-1:0] rf_waddr;
	logic [data_w-1:0]     rf_wdata;

	ex_ctrl_if ex_ch ();
	wb_if      wb_ch ();

	cpu_control u_ctrl (
		.clk, .rst_n,
		.instr        (imem_data),
		.rd1_data, .rd2_data, .flags, .flags_pending, .load_wait, .accel_done,
		.rs1_addr, .rs2_addr, .pc_hold, .branch_taken, .branch_offset,
		.halted, .accel_start, .accel_en,
		.ex           (ex_ch.driver)
	);

	fetch_regfile u_fetch (
		.clk, .rst_n, .pc_hold, .branch_taken, .branch_offset,
		.rs1_addr, .rs2_addr, .rf_wen, .rf_waddr, .rf_wdata,
		.imem_addr, .rd1_data, .rd2_data
	);

	execute_alu u_exec (
		.clk, .rst_n,
		.stall        (load_wait),
		.rf_wen, .rf_waddr, .rf_wdata, .flags, .flags_pending,
		.ex           (ex_ch.receiver),
		.wb           (wb_ch.driver)
	);

	writeback_mux u_wb (
		.clk, .rst_n, .dmem_rdata, .bus_rdata,
		.dmem_ren, .dmem_wren, .dmem_addr, .dmem_wdata,
		.bus_rdwr, .bus_addr, .bus_wdata,
		.rf_wen, .rf_waddr, .rf_wdata, .load_wait,
		.wb           (wb_ch.receiver)
	);

endmodule

`default_nettype wire

//--- bench/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb
	import cpu_isa_pkg::*, cpu_bus_pkg::*;
();

	logic        clk = 1'b0;
	logic        rst_n;
	logic [15:0] imem_data;
	logic [15:0] dmem_rdata;
	logic [15:0] bus_rdata;
	logic        accel_done;
	logic [15:0] imem_addr;
	logic        dmem_ren;
	logic        dmem_wren;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	bus_dir_e    bus_rdwr;
	logic [2:0]  bus_addr;
	logic [15:0] bus_wdata;
	logic        accel_start;
	logic        accel_en;
	logic        halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] acc_regs [8];   // accelerator register file
	logic [15:0] dmem_writes;    // per run
	logic [15:0] starts;         // accel_start pulses seen
	logic [31:0] lfsr_state;
	int          prog_len;
	int          checks;
	int          errors;
	int          timeouts;

	cpu UUT (
		.clk, .rst_n, .imem_data, .dmem_rdata, .bus_rdata, .accel_done,
		.imem_addr, .dmem_ren, .dmem_wren, .dmem_addr, .dmem_wdata,
		.bus_rdwr, .bus_addr, .bus_wdata, .accel_start, .accel_en, .halted
	);

	always #4 clk = ~clk; // 8 ns period

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] fill_word(input logic [7:0] a);
		return {~a, a}; // unwritten dmem word
	endfunction

	function automatic logic [15:0] sext4(input logic [3:0] v);
		return {{12{v[3]}}, v};
	endfunction

	function automatic logic [15:0] pack_fields(input opcode_e op, input logic [3:0] rd,
		input logic [3:0] rs1, input logic [3:0] low);
		return {op, rd, rs1, low};
	endfunction

	function automatic logic [15:0] wide_imm(input opcode_e op, input logic [3:0] rd,
		input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// combinational instruction memory
	always_comb begin
		imem_data = 16'h0000;
		if (!$isunknown(imem_addr))
			imem_data = imem[imem_addr[7:0]];
	end

	// accelerator register read straight from bus_addr
	always_comb begin
		bus_rdata = 16'h0000;
		if (!$isunknown(bus_addr))
			bus_rdata = acc_regs[bus_addr];
	end

	// data memory with one cycle read
	always @(negedge clk) begin
		if (rst_n) begin
			if (dmem_ren && dmem_wren) begin
				errors++;
				$display("data memory saw read and write enable together at %0t ns", $time);
			end
			if (dmem_wren) begin
				dmem[dmem_addr[7:0]] = dmem_wdata;
				dmem_writes = dmem_writes + 16'd1;
			end
			if (dmem_ren)
				dmem_rdata = dmem[dmem_addr[7:0]]; // held through the next cycle
		end
	end

	always @(negedge clk) begin
		if (rst_n && bus_rdwr == bus_write)
			acc_regs[bus_addr] = bus_wdata;
	end

	// accelerator adds r0 and r1 into r2 after a random delay
	always begin : accel_model
		int wait_n;
		@(negedge clk);
		if (rst_n && accel_start) begin
			starts = starts + 16'd1;
			wait_n = 1 + int'(rand_bits(3)); // 1..8 cycles
			repeat (wait_n) begin
				@(negedge clk);
				compare({15'd0, accel_en}, 16'd1, "accel_en while accelerator busy");
			end
			acc_regs[2] = acc_regs[0] + acc_regs[1];
			accel_done = 1'b1;
			@(negedge clk);
			accel_done = 1'b0;
			compare({15'd0, accel_en}, 16'd0, "accel_en after done");
		end
	end

	task automatic emit(input logic [15:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic clear_data();
		for (int i = 0; i < 256; i++)
			dmem[i] = fill_word(i[7:0]);
		for (int i = 0; i < 8; i++)
			acc_regs[i] = 16'h0000;
		dmem_writes = 16'd0;
	endtask

	task automatic new_program();
		for (int i = 0; i < 256; i++)
			imem[i] = {4'hf, 4'h0, i[7:0]}; // halt with low bits from address
		prog_len = 0;
		clear_data();
	endtask

	task automatic reset_core();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		compare({15'd0, halted}, 16'd0, "halted in reset");
		compare(imem_addr, 16'd0, "pc in reset");
		rst_n = 1'b1;
	endtask

	task automatic wait_halted(input int limit);
		int n;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			timeouts++;
			$display("timeout, halted did not go high within %0d cycles", limit);
		end
	endtask

	task automatic arith_forwarding();
		logic [15:0] a, b, c, d, e, f, g, h, k;
		logic [15:0] exp_w [8];
		logic [3:0]  src_r [8];
		a = 16'd100;
		b = 16'd37;
		c = a + b;
		d = c - a;
		e = d ^ c;
		f = e + sext4(4'hd); // addi -3
		g = 16'd0 + f;       // r0 reads zero after the write
		h = c & e;
		k = d | f;
		exp_w = '{c, d, e, f, g, 16'd0, h, k};
		src_r = '{4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd0, 4'd9, 4'd10};
		new_program();
		emit(wide_imm(op_ldi, 4'd8, 8'h40)); // store base
		emit(wide_imm(op_ldi, 4'd1, a[7:0]));
		emit(wide_imm(op_ldi, 4'd2, b[7:0]));
		emit(pack_fields(op_add, 4'd3, 4'd1, 4'd2)); // r2 forwarded, r1 via bypass
		emit(pack_fields(op_sub, 4'd4, 4'd3, 4'd1));
		emit(pack_fields(op_xor, 4'd5, 4'd4, 4'd3));
		emit(pack_fields(op_addi, 4'd6, 4'd5, 4'hd));
		emit(wide_imm(op_ldi, 4'd0, 8'h55));         // write to r0
		emit(pack_fields(op_add, 4'd7, 4'd0, 4'd6));
		emit(pack_fields(op_and, 4'd9, 4'd3, 4'd5));
		emit(pack_fields(op_or, 4'd10, 4'd4, 4'd6));
		for (int i = 0; i < 8; i++)
			emit(pack_fields(op_st, src_r[i], 4'd8, i[3:0]));
		emit(pack_fields(op_halt, 4'd0, 4'd0, 4'd0));
		reset_core();
		wait_halted(200);
		for (int i = 0; i < 8; i++)
			compare(dmem[8'h40 + i], exp_w[i], $sformatf("arith word %0d", i));
	endtask

	task automatic load_store();
		logic [15:0] base, x, y, a_hi, a_lo;
		base = 16'h0030;
		x = 16'd11;
		y = 16'd200;
		a_hi = base + sext4(4'd2);
		a_lo = base + sext4(4'hf); // negative offset
		new_program();
		emit(wide_imm(op_ldi, 4'd1, base[7:0]));
		emit(wide_imm(op_ldi, 4'd2, x[7:0]));
		emit(wide_imm(op_ldi, 4'd3, y[7:0]));
		emit(pack_fields(op_st, 4'd2, 4'd1, 4'd2));
		emit(pack_fields(op_st, 4'd3, 4'd1, 4'hf));
		emit(pack_fields(op_ld, 4'd4, 4'd1, 4'd2));
		emit(pack_fields(op_add, 4'd5, 4'd4, 4'd3));  // uses load result at once
		emit(pack_fields(op_ld, 4'd6, 4'd1, 4'hf));
		emit(pack_fields(op_add, 4'd7, 4'd6, 4'd4));
		emit(pack_fields(op_ld, 4'd8, 4'd1, 4'd2));   // two loads back to back
		emit(pack_fields(op_ld, 4'd9, 4'd1, 4'hf));
		emit(pack_fields(op_sub, 4'd10, 4'd8, 4'd9));
		emit(pack_fields(op_st, 4'd5, 4'd1, 4'd3));
		emit(pack_fields(op_st, 4'd7, 4'd1, 4'd4));
		emit(pack_fields(op_st, 4'd10, 4'd1, 4'd5));
		emit(pack_fields(op_halt, 4'd0, 4'd0, 4'd0));
		reset_core();
		wait_halted(200);
		compare(dmem[a_hi[7:0]], x, "store at positive offset");
		compare(dmem[a_lo[7:0]], y, "store at negative offset");
		compare(dmem[8'h33], x + y, "load then add");
		compare(dmem[8'h34], y + x, "second load then add");
		compare(dmem[8'h35], x - y, "back to back loads");
	endtask

	task automatic branch_paths();
		logic [15:0] p, q, s, cnt, iters, exp_skip, exp_keep;
		int          top;
		int          back;
		p = 16'd5;
		q = 16'd5;
		s = 16'd7;
		// bz +1 skips exactly one word when z is set
		exp_skip = (p - q == 16'd0) ? fill_word(8'h50) : s;
		exp_keep = (s - q == 16'd0) ? fill_word(8'h52) : s;
		cnt = 16'd4;
		iters = 16'd0;
		do begin
			iters = iters + 16'd1;
			cnt = cnt + sext4(4'hf);
		end while (cnt != 16'd0);
		new_program();
		emit(wide_imm(op_ldi, 4'd1, p[7:0]));
		emit(wide_imm(op_ldi, 4'd2, q[7:0]));
		emit(wide_imm(op_ldi, 4'd3, s[7:0]));
		emit(wide_imm(op_ldi, 4'd8, 8'h50));
		emit(pack_fields(op_sub, 4'd4, 4'd1, 4'd2)); // zero
		emit(wide_imm(op_bz, 4'd0, 8'd1));
		emit(pack_fields(op_st, 4'd3, 4'd8, 4'd0)); // skipped
		emit(pack_fields(op_st, 4'd1, 4'd8, 4'd1));
		emit(pack_fields(op_sub, 4'd4, 4'd3, 4'd2)); // nonzero
		emit(wide_imm(op_bz, 4'd0, 8'd1));
		emit(pack_fields(op_st, 4'd3, 4'd8, 4'd2)); // runs
		emit(wide_imm(op_ldi, 4'd5, 8'd4));
		emit(wide_imm(op_ldi, 4'd6, 8'd0));
		top = prog_len;
		emit(pack_fields(op_addi, 4'd6, 4'd6, 4'd1));
		emit(pack_fields(op_addi, 4'd5, 4'd5, 4'hf)); // z at zero
		emit(wide_imm(op_bz, 4'd0, 8'd2));           // exit loop
		emit(pack_fields(op_sub, 4'd0, 4'd0, 4'd0));  // force z
		back = top - prog_len - 1;
		emit(wide_imm(op_bz, 4'd0, back[7:0]));
		emit(pack_fields(op_st, 4'd6, 4'd8, 4'd3));
		emit(pack_fields(op_st, 4'd5, 4'd8, 4'd4));
		emit(pack_fields(op_halt, 4'd0, 4'd0, 4'd0));
		reset_core();
		wait_halted(300);
		compare(dmem[8'h50], exp_skip, "taken branch marker");
		compare(dmem[8'h51], p, "word after skipped store");
		compare(dmem[8'h52], exp_keep, "not taken branch marker");
		compare(dmem[8'h53], iters, "loop iterations");
		compare(dmem[8'h54], cnt, "loop count at exit");
	endtask

	task automatic accelerator_run();
		logic [15:0] a, b;
		logic [15:0] starts_before;
		a = rand_bits(8);
		b = rand_bits(8);
		new_program();
		emit(wide_imm(op_ldi, 4'd1, a[7:0]));
		emit(wide_imm(op_ldi, 4'd2, b[7:0]));
		emit(pack_fields(op_accw, 4'd1, 4'd0, 4'd0));
		emit(pack_fields(op_accw, 4'd2, 4'd0, 4'd1));
		emit(pack_fields(op_accgo, 4'd0, 4'd0, 4'd0));
		emit(pack_fields(op_accr, 4'd3, 4'd0, 4'd2));
		emit(wide_imm(op_ldi, 4'd8, 8'h60));
		emit(pack_fields(op_st, 4'd3, 4'd8, 4'd0));
		emit(pack_fields(op_halt, 4'd0, 4'd0, 4'd0));
		reset_core();
		starts_before = starts;
		wait_halted(200);
		compare(acc_regs[0], a, "accelerator register 0");
		compare(acc_regs[1], b, "accelerator register 1");
		compare(starts - starts_before, 16'd1, "accel_start pulses");
		compare(dmem[8'h60], a + b, "accelerator sum");
	endtask

	task automatic halt_and_reset();
		logic [15:0] v;
		v = 16'h0021;
		new_program();
		emit(wide_imm(op_ldi, 4'd8, 8'h70));
		emit(wide_imm(op_ldi, 4'd1, v[7:0]));
		emit(pack_fields(op_st, 4'd1, 4'd8, 4'd0));
		emit(pack_fields(op_ld, 4'd2, 4'd8, 4'd0));
		emit(pack_fields(op_addi, 4'd3, 4'd2, 4'd1));
		emit(pack_fields(op_st, 4'd3, 4'd8, 4'd1));
		emit(pack_fields(op_halt, 4'd0, 4'd0, 4'd0));
		emit(pack_fields(op_st, 4'd1, 4'd8, 4'd2)); // never reached
		emit(pack_fields(op_st, 4'd1, 4'd8, 4'd3));
		for (int run = 0; run < 2; run++) begin
			clear_data(); // second run from a fresh reset
			reset_core();
			wait_halted(200);
			repeat (16) begin
				@(negedge clk);
				compare({15'd0, halted}, 16'd1, "halted stays high");
			end
			compare(dmem_writes, 16'd2, "dmem writes up to halt");
			compare(dmem[8'h70], v, "store before halt");
			compare(dmem[8'h71], v + sext4(4'd1), "load, addi, store before halt");
			compare(dmem[8'h72], fill_word(8'h72), "word after halt untouched");
			compare(dmem[8'h73], fill_word(8'h73), "second word after halt untouched");
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		accel_done  = 1'b0;
		dmem_rdata  = 16'h0000;
		lfsr_state  = 32'he70091f1;
		starts      = 16'd0;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		new_program();
		arith_forwarding();
		load_store();
		branch_paths();
		accelerator_run();
		halt_and_reset();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/stage_if.sv
hw/cpu_control.sv
hw/fetch_regfile.sv
hw/execute_alu.sv
hw/writeback_mux.sv
hw/cpu.sv
bench/cpu_tb.sv
